//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_lenet_mac
FILELIST  ?= lenet_mac.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS    := $(shell grep -v '^+' $(FILELIST))
HDRS    := $(wildcard tests/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run check clean

all: check

build: $(SIM_BIN)

# rebuilt only when a source, a header or the file list changes
$(SIM_BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) 2>&1 | tee $(LOG)

check: run
	@if grep -qx '>>> PASS' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- common/lenet_pkg.sv
package lenet_pkg;

    localparam int DATA_W  = 8;
    localparam int PROD_W  = 2 * DATA_W;
    localparam int ACC_W   = 20;           // 16 full-scale products fit
    localparam int VEC_LEN = 16;
    localparam int ADDR_W  = 8;            // 256 words
    localparam int CNT_W   = 5;

    localparam logic [CNT_W-1:0] LAST_IDX = CNT_W'(VEC_LEN - 1);

    // lane states
    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_FETCH = 2'd1;
    localparam logic [1:0] ST_DRAIN = 2'd2;
    localparam logic [1:0] ST_DONE  = 2'd3;

    // one memory word, raw for the host and RAM, split for the lanes
    typedef union packed {
        logic [2*DATA_W-1:0] raw;
        struct packed {
            logic [DATA_W-1:0] weight;   // upper byte
            logic [DATA_W-1:0] act;
        } pair;
    } mem_word_t;

endpackage

//--- lenet_mac.f
common/lenet_pkg.sv
verilog/approx_mult8.sv
verilog/feature_ram.sv
verilog/mem_arbiter.sv
mac_lane/mac_lane.sv
verilog/lenet_mac_top.sv
+incdir+tests
tests/tb_lenet_mac.sv

//--- mac_lane/mac_lane.sv
`timescale 1ns/1ps

module mac_lane (
    input  logic                         clk,
    input  logic                         arst_n,
    // job channel
    input  logic                         job_valid,
    output logic                         job_ready,
    input  logic [lenet_pkg::ADDR_W-1:0] job_base,
    // memory read port
    output logic                         req,
    output logic [lenet_pkg::ADDR_W-1:0] req_addr,
    input  logic                         gnt,
    input  logic                         rsp_valid,
    input  lenet_pkg::mem_word_t         rsp_data,
    // result channel
    output logic                         res_valid,
    input  logic                         res_ready,
    output logic [lenet_pkg::ACC_W-1:0]  res_sum
);

    logic [1:0]                        state;
    logic [lenet_pkg::CNT_W-1:0]       issue_cnt;   // grants seen
    logic [lenet_pkg::CNT_W-1:0]       recv_cnt;    // products added
    logic [lenet_pkg::ADDR_W-1:0]      addr_q;
    logic [lenet_pkg::PROD_W-1:0]      mult_p;
    logic [lenet_pkg::PROD_W-1:0]      prod_q;
    logic                              prod_vld;
    logic [lenet_pkg::ACC_W-1:0]       acc_q;
    logic                              job_go;
    logic                              add_last;

    // ##############################
    // multiplier
    // ##############################

    approx_mult8 u_mult (
        .a (rsp_data.pair.act),
        .b (rsp_data.pair.weight),
        .p (mult_p)
    );

    // ##############################
    // control
    // ##############################

    assign job_ready = (state == lenet_pkg::ST_IDLE);
    assign job_go    = job_valid && job_ready;
    assign req       = (state == lenet_pkg::ST_FETCH);
    assign req_addr  = addr_q;
    assign add_last  = prod_vld && (recv_cnt == lenet_pkg::LAST_IDX);
    assign res_valid = (state == lenet_pkg::ST_DONE);
    assign res_sum   = acc_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= lenet_pkg::ST_IDLE;
            issue_cnt <= '0;
            recv_cnt  <= '0;
            prod_vld  <= 1'b0;
        end else begin
            prod_vld <= rsp_valid;
            if (prod_vld) begin
                recv_cnt <= recv_cnt + 1'b1;
            end
            case (state)
                lenet_pkg::ST_IDLE: begin
                    if (job_valid) begin
                        state     <= lenet_pkg::ST_FETCH;
                        issue_cnt <= '0;
                        recv_cnt  <= '0;
                    end
                end
                lenet_pkg::ST_FETCH: begin
                    if (gnt) begin
                        issue_cnt <= issue_cnt + 1'b1;
                        if (issue_cnt == lenet_pkg::LAST_IDX) begin
                            state <= lenet_pkg::ST_DRAIN;   // all reads issued
                        end
                    end
                end
                lenet_pkg::ST_DRAIN: begin
                    if (add_last) begin
                        state <= lenet_pkg::ST_DONE;
                    end
                end
                lenet_pkg::ST_DONE: begin
                    if (res_ready) begin
                        state <= lenet_pkg::ST_IDLE;
                    end
                end
                default: state <= lenet_pkg::ST_IDLE;
            endcase
        end
    end

    // ##############################
    // datapath
    // ##############################

    always_ff @(posedge clk) begin
        if (rsp_valid) begin
            prod_q <= mult_p;   // stage 1, product of the arriving pair
        end
        if (job_go) begin
            addr_q <= job_base;
            acc_q  <= '0;
        end else begin
            if (gnt) begin
                addr_q <= addr_q + 1'b1;
            end
            if (prod_vld) begin
                acc_q <= acc_q + {{(lenet_pkg::ACC_W - lenet_pkg::PROD_W){1'b0}}, prod_q};
            end
        end
    end

    a_res_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        res_valid && !res_ready |=> res_valid && $stable(res_sum)
    ) else $error("mac_lane: result changed under back-pressure");

endmodule

//--- tests/tb_lenet_mac_tasks.svh
`ifndef TB_LENET_MAC_TASKS_SVH
`define TB_LENET_MAC_TASKS_SVH

    // ##############################
    // random bits and reference model
    // ##############################

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic next_bit();
        logic fb;
        fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic logic [lenet_pkg::DATA_W-1:0] rand_byte();
        logic [lenet_pkg::DATA_W-1:0] v;
        v = '0;
        for (int i = 0; i < lenet_pkg::DATA_W; i++) begin
            v = {v[lenet_pkg::DATA_W-2:0], next_bit()};
        end
        return v;
    endfunction

    function automatic logic [lenet_pkg::PROD_W-1:0] model_mult(
        input logic [lenet_pkg::DATA_W-1:0] a,
        input logic [lenet_pkg::DATA_W-1:0] b
    );
        logic [7:0] r [8];   // r[i][j] = a[i] & b[j]
        int         exact;
        int         lower;
        for (int i = 0; i < 8; i++) begin
            r[i] = b & {8{a[i]}};
        end
        exact = int'(r[6]) * 64 + int'(r[7]) * 128;
        // each lower column counts its pruned single-bit terms
        lower = 128  * (int'(r[0][6] & r[1][5]) + int'(r[0][7] & r[1][6])
                      + int'(r[4][2] | r[5][1]))
              + 256  * (int'(r[0][7] ^ r[1][6]) + int'(r[2][5] | r[3][4])
                      + int'(r[2][6] | r[3][5]))
              + 512  * (int'(r[2][7] | r[3][6]) + int'(r[4][4] | r[5][3])
                      + int'(r[4][5] & r[5][4]) + int'(r[4][5] | r[5][4]))
              + 1024 * (int'(r[2][7] & r[3][6]) + int'(r[3][7])
                      + int'(r[4][6] & r[5][5]) + int'(r[4][6] | r[5][5]))
              + 2048 * (int'(r[4][7] & r[5][6]) + int'(r[4][7] | r[5][6]))
              + 4096 * int'(r[5][7]);
        return lenet_pkg::PROD_W'(exact + lower);
    endfunction

    // dot product over the shadow copy, exact or through the model
    function automatic logic [lenet_pkg::ACC_W-1:0] model_sum(
        input logic [lenet_pkg::ADDR_W-1:0] base,
        input logic                         exact
    );
        lenet_pkg::mem_word_t        w;
        logic [lenet_pkg::ACC_W-1:0] s;
        s = '0;
        for (int i = 0; i < lenet_pkg::VEC_LEN; i++) begin
            w = shadow[base + lenet_pkg::ADDR_W'(i)];
            if (exact) begin
                s = s + lenet_pkg::ACC_W'(w.pair.act) * lenet_pkg::ACC_W'(w.pair.weight);
            end else begin
                s = s + lenet_pkg::ACC_W'(model_mult(w.pair.act, w.pair.weight));
            end
        end
        return s;
    endfunction

    // ##############################
    // compare tasks
    // ##############################

    task automatic check_sum(
        input string                       name,
        input logic [lenet_pkg::ACC_W-1:0] exp,
        input logic [lenet_pkg::ACC_W-1:0] act
    );
        check_cnt++;
        if (act !== exp) begin
            error_cnt++;
            $display("Fail %s: expected 0x%h, got 0x%h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        check_cnt++;
        if (act !== exp) begin
            error_cnt++;
            $display("Fail %s: expected 0x%h, got 0x%h", name, exp, act);
        end
    endtask

    // ##############################
    // drivers
    // ##############################

    task automatic load_word(
        input logic [lenet_pkg::ADDR_W-1:0] addr,
        input lenet_pkg::mem_word_t         word
    );
        logic done;
        @(negedge clk);
        load_valid = 1'b1;
        load_addr  = addr;
        load_data  = word;
        done       = 1'b0;
        while (!done) begin
            #1;
            done = load_ready;   // ready has settled well before the next edge
            @(negedge clk);
        end
        load_valid   = 1'b0;
        shadow[addr] = word;
    endtask

    task automatic start_job(input int lane, input logic [lenet_pkg::ADDR_W-1:0] base);
        logic taken;
        @(negedge clk);
        job_valid[lane] = 1'b1;
        job_base[lane]  = base;
        taken           = 1'b0;
        while (!taken) begin
            taken = job_ready[lane];
            @(negedge clk);
        end
        job_valid[lane] = 1'b0;
    endtask

    // holds res_ready low for hold cycles before taking the result
    task automatic wait_result(
        input int                          lane,
        input logic [lenet_pkg::ACC_W-1:0] exp,
        input int                          hold
    );
        string                       sfx;
        logic [lenet_pkg::ACC_W-1:0] held;
        sfx = $sformatf("_%0d", lane);
        @(negedge clk);
        while (!res_valid[lane]) begin
            @(negedge clk);
        end
        held = res_sum[lane];
        check_sum({"res_sum", sfx}, exp, held);
        repeat (hold) begin
            @(negedge clk);
            check_flag({"res_valid", sfx}, 1'b1, res_valid[lane]);
            check_flag({"job_ready", sfx}, 1'b0, job_ready[lane]);
            check_sum({"res_sum", sfx}, held, res_sum[lane]);
        end
        res_ready[lane] = 1'b1;
        @(negedge clk);
        res_ready[lane] = 1'b0;
        check_flag({"res_valid", sfx}, 1'b0, res_valid[lane]);
        check_flag({"job_ready", sfx}, 1'b1, job_ready[lane]);   // lane back in idle
    endtask

`endif

//--- tests/tb_lenet_mac.sv
`timescale 1ns/1ps

module tb_lenet_mac;

    localparam int N_JOBS      = 12;
    localparam int N_LOADS     = 128;
    localparam int CYCLE_LIMIT = (N_JOBS * (lenet_pkg::VEC_LEN + 8) * 2 + N_LOADS * 2) * 2;

    logic                              clk;
    logic                              arst_n;
    logic                              load_valid;
    logic                              load_ready;
    logic [lenet_pkg::ADDR_W-1:0]      load_addr;
    lenet_pkg::mem_word_t              load_data;
    logic [1:0]                        job_valid;
    wire  [1:0]                        job_ready;
    logic [1:0][lenet_pkg::ADDR_W-1:0] job_base;
    wire  [1:0]                        res_valid;
    logic [1:0]                        res_ready;
    wire  [1:0][lenet_pkg::ACC_W-1:0]  res_sum;

    lenet_pkg::mem_word_t shadow [2**lenet_pkg::ADDR_W];   // host copy of the RAM
    logic [15:0]          lfsr_q;
    int                   check_cnt;
    int                   error_cnt;
    int                   cycle_cnt;

    lenet_mac_top uut (
        .clk         (clk),
        .arst_n      (arst_n),
        .load_valid  (load_valid),
        .load_ready  (load_ready),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .job_valid_0 (job_valid[0]),
        .job_ready_0 (job_ready[0]),
        .job_base_0  (job_base[0]),
        .res_valid_0 (res_valid[0]),
        .res_ready_0 (res_ready[0]),
        .res_sum_0   (res_sum[0]),
        .job_valid_1 (job_valid[1]),
        .job_ready_1 (job_ready[1]),
        .job_base_1  (job_base[1]),
        .res_valid_1 (res_valid[1]),
        .res_ready_1 (res_ready[1]),
        .res_sum_1   (res_sum[1])
    );

    `include "tb_lenet_mac_tasks.svh"

    // ##############################
    // directed tests
    // ##############################

    // activations with bits 5..0 clear only reach rows 6 and 7
    task automatic exact_region_test();
        for (int i = 0; i < lenet_pkg::VEC_LEN; i++) begin
            load_word(lenet_pkg::ADDR_W'(i), {rand_byte(), rand_byte() & 8'hc0});
        end
        for (int lane = 0; lane < 2; lane++) begin
            start_job(lane, 8'd0);
            wait_result(lane, model_sum(8'd0, 1'b1), 0);
        end
    endtask

    task automatic zero_test();
        for (int i = 0; i < lenet_pkg::VEC_LEN; i++) begin
            load_word(lenet_pkg::ADDR_W'(16 + i), {8'h00, rand_byte()});   // no weights
            load_word(lenet_pkg::ADDR_W'(32 + i), {rand_byte(), 8'h00});   // no activations
        end
        for (int lane = 0; lane < 2; lane++) begin
            start_job(lane, 8'd16);
            wait_result(lane, '0, 0);
            start_job(lane, 8'd32);
            wait_result(lane, '0, 0);
        end
    endtask

    task automatic random_test();
        for (int i = 0; i < 2 * lenet_pkg::VEC_LEN; i++) begin
            load_word(lenet_pkg::ADDR_W'(48 + i), {rand_byte(), rand_byte()});
        end
        start_job(0, 8'd48);
        wait_result(0, model_sum(8'd48, 1'b0), 0);
        start_job(1, 8'd64);
        wait_result(1, model_sum(8'd64, 1'b0), 0);
    endtask

    task automatic concurrent_test();
        logic [lenet_pkg::ACC_W-1:0] exp_0;
        logic [lenet_pkg::ACC_W-1:0] exp_1;
        for (int i = 0; i < 2 * lenet_pkg::VEC_LEN; i++) begin
            load_word(lenet_pkg::ADDR_W'(80 + i), {rand_byte(), rand_byte()});
        end
        exp_0 = model_sum(8'd80, 1'b0);
        exp_1 = model_sum(8'd96, 1'b0);
        fork
            begin
                start_job(0, 8'd80);
                wait_result(0, exp_0, 0);
            end
            begin
                start_job(1, 8'd96);
                wait_result(1, exp_1, 0);
            end
            begin
                // host writes steal RAM cycles from both lanes
                for (int i = 0; i < lenet_pkg::VEC_LEN; i++) begin
                    load_word(lenet_pkg::ADDR_W'(200 + i), {rand_byte(), rand_byte()});
                end
            end
        join
    endtask

    task automatic backpressure_test();
        start_job(0, 8'd48);
        wait_result(0, model_sum(8'd48, 1'b0), 20);   // consumer stalls 20 cycles
        start_job(0, 8'd64);
        wait_result(0, model_sum(8'd64, 1'b0), 0);
    endtask

    // ##############################
    // clock, timeout, sequence
    // ##############################

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: tests still running after %0d cycles", CYCLE_LIMIT);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        arst_n     = 1'b0;
        load_valid = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        job_valid  = '0;
        job_base   = '0;
        res_ready  = '0;
        lfsr_q     = 16'd94;
        check_cnt  = 0;
        error_cnt  = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        check_flag("job_ready_0", 1'b1, job_ready[0]);
        check_flag("job_ready_1", 1'b1, job_ready[1]);
        check_flag("res_valid_0", 1'b0, res_valid[0]);
        check_flag("res_valid_1", 1'b0, res_valid[1]);
        check_flag("load_ready", 1'b0, load_ready);   // no load pending
        exact_region_test();
        zero_test();
        random_test();
        concurrent_test();
        backpressure_test();
        $display("checks %0d, errors %0d", check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- verilog/approx_mult8.sv
`timescale 1ns/1ps

module approx_mult8 (
    input  logic [lenet_pkg::DATA_W-1:0] a,   // activation
    input  logic [lenet_pkg::DATA_W-1:0] b,   // weight
    output logic [lenet_pkg::PROD_W-1:0] p
);

    logic [lenet_pkg::DATA_W-1:0] row [lenet_pkg::DATA_W];

    // pruned contributions of rows 0..5, bit positions 12 down to 7
    logic [12:7] term0;
    logic [12:7] term1;
    logic [12:7] term2;
    logic [12:7] term3;

    logic [lenet_pkg::PROD_W-1:0] exact_hi;
    logic [lenet_pkg::PROD_W-1:0] pruned;

    // ##############################
    // partial product rows
    // ##############################

    for (genvar i = 0; i < lenet_pkg::DATA_W; i++) begin : g_row
        assign row[i] = b & {lenet_pkg::DATA_W{a[i]}};
    end

    // ##############################
    // pruned lower rows
    // ##############################

    assign term0[7]  = row[0][6] & row[1][5];
    assign term0[8]  = row[0][7] ^ row[1][6];
    assign term0[9]  = row[2][7] | row[3][6];
    assign term0[10] = row[2][7] & row[3][6];
    assign term0[11] = row[4][7] & row[5][6];
    assign term0[12] = row[5][7];

    assign term1[7]  = row[0][7] & row[1][6];
    assign term1[8]  = row[2][5] | row[3][4];
    assign term1[9]  = row[4][4] | row[5][3];
    assign term1[10] = row[3][7];
    assign term1[11] = row[4][7] | row[5][6];
    assign term1[12] = 1'b0;

    assign term2[7]  = row[4][2] | row[5][1];
    assign term2[8]  = row[2][6] | row[3][5];
    assign term2[9]  = row[4][5] & row[5][4];
    assign term2[10] = row[4][6] & row[5][5];
    assign term2[11] = 1'b0;
    assign term2[12] = 1'b0;

    // only two bits survive in the last group
    assign term3[7]  = 1'b0;
    assign term3[8]  = 1'b0;
    assign term3[9]  = row[4][5] | row[5][4];
    assign term3[10] = row[4][6] | row[5][5];
    assign term3[11] = 1'b0;
    assign term3[12] = 1'b0;

    // ##############################
    // final sum
    // ##############################

    assign exact_hi = {2'b00, row[6], 6'b0} + {1'b0, row[7], 7'b0};

    assign pruned = {3'b000, term0, 7'b0}
                  + {3'b000, term1, 7'b0}
                  + {3'b000, term2, 7'b0}
                  + {3'b000, term3, 7'b0};

    assign p = exact_hi + pruned;   // bits 6..0 of the pruned part stay zero

endmodule

//--- verilog/feature_ram.sv
`timescale 1ns/1ps

module feature_ram (
    input  logic                         clk,
    input  logic                         en,
    input  logic                         we,
    input  logic [lenet_pkg::ADDR_W-1:0] addr,
    input  lenet_pkg::mem_word_t         wdata,
    output lenet_pkg::mem_word_t         rdata
);

    lenet_pkg::mem_word_t mem [2**lenet_pkg::ADDR_W];

    // one-cycle read, rdata holds over a write
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

    // an unknown address would corrupt or return garbage
    a_addr_known: assert property (
        @(posedge clk) en |-> !$isunknown(addr)
    ) else $error("feature_ram: unknown address with en high");

endmodule

//--- verilog/lenet_mac_top.sv
`timescale 1ns/1ps

module lenet_mac_top (
    input  logic                         clk,
    input  logic                         arst_n,
    // host load
    input  logic                         load_valid,
    output logic                         load_ready,
    input  logic [lenet_pkg::ADDR_W-1:0] load_addr,
    input  lenet_pkg::mem_word_t         load_data,
    // lane 0
    input  logic                         job_valid_0,
    output logic                         job_ready_0,
    input  logic [lenet_pkg::ADDR_W-1:0] job_base_0,
    output logic                         res_valid_0,
    input  logic                         res_ready_0,
    output logic [lenet_pkg::ACC_W-1:0]  res_sum_0,
    // lane 1
    input  logic                         job_valid_1,
    output logic                         job_ready_1,
    input  logic [lenet_pkg::ADDR_W-1:0] job_base_1,
    output logic                         res_valid_1,
    input  logic                         res_ready_1,
    output logic [lenet_pkg::ACC_W-1:0]  res_sum_1
);

    logic                         req_0;
    logic                         req_1;
    logic [lenet_pkg::ADDR_W-1:0] req_addr_0;
    logic [lenet_pkg::ADDR_W-1:0] req_addr_1;
    logic                         gnt_0;
    logic                         gnt_1;
    logic                         rsp_valid_0;
    logic                         rsp_valid_1;
    lenet_pkg::mem_word_t         rsp_data;
    logic                         ram_en;
    logic                         ram_we;
    logic [lenet_pkg::ADDR_W-1:0] ram_addr;
    lenet_pkg::mem_word_t         ram_wdata;
    lenet_pkg::mem_word_t         ram_rdata;

    feature_ram u_ram (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    mem_arbiter u_arb (
        .clk         (clk),
        .arst_n      (arst_n),
        .load_valid  (load_valid),
        .load_ready  (load_ready),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .req_0       (req_0),
        .req_1       (req_1),
        .req_addr_0  (req_addr_0),
        .req_addr_1  (req_addr_1),
        .gnt_0       (gnt_0),
        .gnt_1       (gnt_1),
        .rsp_valid_0 (rsp_valid_0),
        .rsp_valid_1 (rsp_valid_1),
        .rsp_data    (rsp_data),
        .ram_en      (ram_en),
        .ram_we      (ram_we),
        .ram_addr    (ram_addr),
        .ram_wdata   (ram_wdata),
        .ram_rdata   (ram_rdata)
    );

    mac_lane lane_0 (
        .clk (clk), .arst_n (arst_n),
        .job_valid (job_valid_0), .job_ready (job_ready_0), .job_base (job_base_0),
        .req (req_0), .req_addr (req_addr_0), .gnt (gnt_0),
        .rsp_valid (rsp_valid_0), .rsp_data (rsp_data),
        .res_valid (res_valid_0), .res_ready (res_ready_0), .res_sum (res_sum_0)
    );

    mac_lane lane_1 (
        .clk (clk), .arst_n (arst_n),
        .job_valid (job_valid_1), .job_ready (job_ready_1), .job_base (job_base_1),
        .req (req_1), .req_addr (req_addr_1), .gnt (gnt_1),
        .rsp_valid (rsp_valid_1), .rsp_data (rsp_data),
        .res_valid (res_valid_1), .res_ready (res_ready_1), .res_sum (res_sum_1)
    );

endmodule

//--- verilog/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                         clk,
    input  logic                         arst_n,
    // host load channel
    input  logic                         load_valid,
    output logic                         load_ready,
    input  logic [lenet_pkg::ADDR_W-1:0] load_addr,
    input  lenet_pkg::mem_word_t         load_data,
    // lane read requests
    input  logic                         req_0,
    input  logic                         req_1,
    input  logic [lenet_pkg::ADDR_W-1:0] req_addr_0,
    input  logic [lenet_pkg::ADDR_W-1:0] req_addr_1,
    output logic                         gnt_0,
    output logic                         gnt_1,
    // read responses
    output logic                         rsp_valid_0,
    output logic                         rsp_valid_1,
    output lenet_pkg::mem_word_t         rsp_data,
    // RAM side
    output logic                         ram_en,
    output logic                         ram_we,
    output logic [lenet_pkg::ADDR_W-1:0] ram_addr,
    output lenet_pkg::mem_word_t         ram_wdata,
    input  lenet_pkg::mem_word_t         ram_rdata
);

    logic rr_ptr;     // 1 = lane 1 preferred
    logic rsp_pend;
    logic rsp_tag;    // lane owning the pending response

    assign load_ready = load_valid;   // host always wins

    always_comb begin
        gnt_0 = 1'b0;
        gnt_1 = 1'b0;
        if (!load_valid) begin
            if (req_0 && req_1) begin
                gnt_0 = !rr_ptr;
                gnt_1 = rr_ptr;
            end else begin
                gnt_0 = req_0;
                gnt_1 = req_1;
            end
        end
    end

    assign ram_en    = load_valid || gnt_0 || gnt_1;
    assign ram_we    = load_valid;
    assign ram_addr  = load_valid ? load_addr : (gnt_1 ? req_addr_1 : req_addr_0);
    assign ram_wdata = load_data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rr_ptr   <= 1'b0;
            rsp_pend <= 1'b0;
            rsp_tag  <= 1'b0;
        end else begin
            if (gnt_0 || gnt_1) begin
                rr_ptr <= gnt_0;   // point at the other lane
            end
            rsp_pend <= gnt_0 || gnt_1;
            rsp_tag  <= gnt_1;
        end
    end

    assign rsp_valid_0 = rsp_pend && !rsp_tag;
    assign rsp_valid_1 = rsp_pend && rsp_tag;
    assign rsp_data    = ram_rdata;   // shared by both lanes

    a_one_owner: assert property (
        @(posedge clk) disable iff (!arst_n) $onehot0({gnt_0, gnt_1, load_ready})
    ) else $error("mem_arbiter: more than one requester granted");

endmodule
